// ==== branch_predict_top.f ====
+incdir+src
src/branch_pkg.sv
src/fp_compare.sv
src/branch_unit.sv
src/pht_ram.sv
src/gshare_predictor.sv
src/branch_resolve.sv
src/branch_predict_top.sv
tb/tb_branch_predict.sv

// ==== Bender.yml ====
package:
  name: branch_predict

sources:
  - include_dirs:
      - src
    files:
      - src/branch_pkg.sv
      - src/fp_compare.sv
      - src/branch_unit.sv
      - src/pht_ram.sv
      - src/gshare_predictor.sv
      - src/branch_resolve.sv
      - src/branch_predict_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/tb_branch_predict.sv

// ==== tb/tb_branch_predict.sv ====
`timescale 1ns/1ps

`include "branch_config.svh"

module tb_branch_predict;

    // Upper bounds on the work done by the tests, used for the watchdog
    localparam int RESOLVE_COUNT   = 82;
    localparam int PREDICT_COUNT   = 53;
    localparam int WATCHDOG_CYCLES = 2 * (256 + 6 * RESOLVE_COUNT + 2 * PREDICT_COUNT);
    localparam int IW              = `BP_PHT_INDEX_WIDTH;

    // Integer and unused codes for the random mix
    localparam logic [2:0] MIX_OPS [6] = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd6, 3'd7};

    logic                     clk;
    logic                     rstn;
    branch_pkg::predict_req_t predict_req;
    branch_pkg::predict_rsp_t predict_rsp;
    logic                     resolve_req_valid;
    branch_pkg::resolve_req_t resolve_req;
    logic                     resolve_ack;
    branch_pkg::resolve_rsp_t resolve_rsp;
    logic                     ready;

    // Reference model of the table and global history
    logic [1:0]    model_pht [1 << IW];
    logic [IW-1:0] model_hist;

    int errors;
    int checks;

    branch_predict_top dut0 (
        .clk               (clk),
        .rstn              (rstn),
        .predict_req       (predict_req),
        .predict_rsp       (predict_rsp),
        .resolve_req_valid (resolve_req_valid),
        .resolve_req       (resolve_req),
        .resolve_ack       (resolve_ack),
        .resolve_rsp       (resolve_rsp),
        .ready             (ready)
    );

    always #10 clk = ~clk;

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic check_predict(input branch_pkg::predict_rsp_t got,
                                 input branch_pkg::predict_rsp_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s: valid=%0b taken=%0b index=%02h, expected %0b %0b %02h",
                     $time, what, got.valid, got.taken, got.index,
                     exp.valid, exp.taken, exp.index);
        end
    endtask

    task automatic check_resolve(input branch_pkg::resolve_rsp_t got,
                                 input branch_pkg::resolve_rsp_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s: resolve taken=%0b mispredict=%0b, expected %0b %0b",
                     $time, what, got.taken, got.mispredict, exp.taken, exp.mispredict);
        end
    endtask

    ////////////////////
    // Model helpers
    ////////////////////

    function automatic logic int_branch_taken(input logic [2:0] op,
                                              input logic [31:0] a, input logic [31:0] b);
        case (op)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd2:    return $signed(a) < $signed(b);
            3'd3:    return $signed(a) >= $signed(b);
            default: return 1'b0;
        endcase
    endfunction

    // PC whose hash with the current history lands on idx
    function automatic logic [31:0] pc_for_index(input logic [IW-1:0] idx);
        logic [31:0] pc;
        pc = $urandom;
        pc[IW+1:2] = idx ^ model_hist;
        return pc;
    endfunction

    ////////////////////
    // Port tasks
    ////////////////////

    task automatic predict(input logic [31:0] pc, input string what,
                           output branch_pkg::predict_rsp_t got);
        branch_pkg::predict_rsp_t exp;
        exp.valid = 1'b1;
        exp.index = pc[IW+1:2] ^ model_hist;
        exp.taken = model_pht[exp.index][1];
        @(posedge clk);
        predict_req <= {1'b1, pc};
        @(posedge clk);
        predict_req.valid <= 1'b0;
        @(negedge clk);
        got = predict_rsp;
        check_predict(got, exp, what);
    endtask

    // Full four-phase handshake, then training of the model
    task automatic resolve(input logic [2:0] op, input logic [31:0] a, input logic [31:0] b,
                           input logic [IW-1:0] idx, input logic pred,
                           input logic exp_taken, input string what);
        branch_pkg::resolve_req_t r;
        branch_pkg::resolve_rsp_t exp;
        int cycles;
        r.op         = branch_pkg::branch_op_e'(op);
        r.src0       = a;
        r.src1       = b;
        r.index      = idx;
        r.pred_taken = pred;
        @(posedge clk);
        resolve_req       <= r;
        resolve_req_valid <= 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!resolve_ack && cycles < 16);
        // Req is sampled on the edge after it is driven
        if (!resolve_ack) begin
            errors++;
            $display("%s: resolve handshake stalled, ack never rose", what);
        end else if (cycles != 5) begin
            errors++;
            $display("error at %0t: %s: ack %0d cycles after req, expected 3",
                     $time, what, cycles - 2);
        end
        exp.taken      = exp_taken;
        exp.mispredict = exp_taken ^ pred;
        check_resolve(resolve_rsp, exp, what);
        @(posedge clk);
        resolve_req_valid <= 1'b0;
        @(negedge clk);
        if (!resolve_ack) begin
            errors++;
            $display("%s: ack dropped before req was seen low", what);
        end
        cycles = 0;
        while (resolve_ack && cycles < 8) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles != 2) begin
            errors++;
            $display("error at %0t: %s: ack fell %0d cycles after req, expected 2",
                     $time, what, cycles);
        end
        if (exp_taken && model_pht[idx] != 2'd3) begin
            model_pht[idx] = model_pht[idx] + 2'd1;
        end else if (!exp_taken && model_pht[idx] != 2'd0) begin
            model_pht[idx] = model_pht[idx] - 2'd1;
        end
        model_hist = {model_hist[IW-2:0], exp_taken};
    endtask

    task automatic branch_case(input logic [2:0] op, input logic [31:0] a,
                               input logic [31:0] b, input logic exp_taken, input string what);
        resolve(op, a, b, $urandom_range(255, 0), $urandom_range(1, 0), exp_taken, what);
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic reset_and_ready();
        branch_pkg::predict_rsp_t got;
        branch_pkg::predict_rsp_t exp;
        logic [31:0] pc;
        int cycles;
        @(posedge clk);
        @(negedge clk);
        if (ready || predict_rsp.valid || resolve_ack) begin
            errors++;
            $display("Outputs not inactive during reset");
        end
        @(posedge clk);
        rstn <= 1'b1;
        // First walk cycle is the edge after rstn rises
        @(negedge clk);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!ready && cycles < 1000);
        if (cycles != 256) begin
            errors++;
            $display("Ready rose after %0d cycles instead of 256", cycles);
        end
        for (int i = 0; i < 8; i++) begin
            pc = $urandom;
            predict(pc, "predict after reset", got);
            exp = {1'b1, 1'b0, pc[IW+1:2]};
            check_predict(got, exp, "index with zero history");
        end
    endtask

    task automatic integer_branches();
        branch_case(3'd0, 32'd5, 32'd5, 1'b1, "beq equal");
        branch_case(3'd0, 32'd5, 32'd6, 1'b0, "beq unequal");
        branch_case(3'd1, 32'd5, 32'd6, 1'b1, "bne unequal");
        branch_case(3'd1, 32'd7, 32'd7, 1'b0, "bne equal");
        branch_case(3'd2, 32'h8000_0000, 32'h7fff_ffff, 1'b1, "blt min max");
        branch_case(3'd2, 32'h7fff_ffff, 32'h8000_0000, 1'b0, "blt max min");
        branch_case(3'd3, 32'h8000_0000, 32'h7fff_ffff, 1'b0, "bge min max");
        branch_case(3'd3, 32'h7fff_ffff, 32'h8000_0000, 1'b1, "bge max min");
        branch_case(3'd3, 32'd3, 32'd3, 1'b1, "bge equal");
        branch_case(3'd2, 32'hffff_ffff, 32'd0, 1'b1, "blt minus one");
        branch_case(3'd6, 32'd1, 32'd1, 1'b0, "unused code 6");
        branch_case(3'd7, 32'd0, 32'd0, 1'b0, "unused code 7");
    endtask

    task automatic float_branches();
        // Codes 4 and 5 are feq and fle
        branch_case(3'd4, 32'h0000_0000, 32'h8000_0000, 1'b1, "feq +0 -0");
        branch_case(3'd5, 32'h0000_0000, 32'h8000_0000, 1'b1, "fle +0 -0");
        branch_case(3'd5, 32'h8000_0000, 32'h0000_0000, 1'b1, "fle -0 +0");
        branch_case(3'd4, 32'h7fc0_0000, 32'h3f80_0000, 1'b0, "feq nan 1.0");
        branch_case(3'd5, 32'h7fc0_0000, 32'h3f80_0000, 1'b0, "fle nan 1.0");
        branch_case(3'd5, 32'h3f80_0000, 32'h7fc0_0000, 1'b0, "fle 1.0 nan");
        branch_case(3'd4, 32'h7fc0_0000, 32'h7fc0_0000, 1'b0, "feq nan nan");
        branch_case(3'd4, 32'hbf80_0000, 32'h3f80_0000, 1'b0, "feq -1.0 1.0");
        branch_case(3'd5, 32'hbf80_0000, 32'h3f80_0000, 1'b1, "fle -1.0 1.0");
        branch_case(3'd5, 32'h3f80_0000, 32'hbf80_0000, 1'b0, "fle 1.0 -1.0");
        branch_case(3'd5, 32'hc000_0000, 32'hbf80_0000, 1'b1, "fle -2.0 -1.0");
        branch_case(3'd5, 32'hbf80_0000, 32'hc000_0000, 1'b0, "fle -1.0 -2.0");
        branch_case(3'd4, 32'h3fc0_0000, 32'h3fc0_0000, 1'b1, "feq 1.5 1.5");
        branch_case(3'd5, 32'h3fc0_0000, 32'h3fc0_0000, 1'b1, "fle 1.5 1.5");
        branch_case(3'd5, 32'h3f80_0000, 32'h4000_0000, 1'b1, "fle 1.0 2.0");
    endtask

    task automatic counter_training();
        branch_pkg::predict_rsp_t got;
        logic [IW-1:0] idx;
        idx = 8'hc3;
        repeat (2) resolve(3'd0, 32'd9, 32'd9, idx, 1'b0, 1'b1, "train taken");
        predict(pc_for_index(idx), "after two taken", got);
        repeat (3) resolve(3'd0, 32'd9, 32'd9, idx, 1'b1, 1'b1, "saturate taken");
        predict(pc_for_index(idx), "after saturation", got);
        resolve(3'd0, 32'd9, 32'd8, idx, 1'b1, 1'b0, "first not taken");
        predict(pc_for_index(idx), "one step down", got);
        resolve(3'd0, 32'd9, 32'd8, idx, 1'b1, 1'b0, "second not taken");
        predict(pc_for_index(idx), "two steps down", got);
    endtask

    task automatic history_hash();
        branch_pkg::predict_rsp_t got;
        branch_pkg::predict_rsp_t exp;
        logic [IW-1:0] pattern;
        logic [31:0]   pc;
        pattern = 8'b1011_0010;
        for (int i = IW - 1; i >= 0; i--) begin
            branch_case(3'd0, 32'd1, pattern[i] ? 32'd1 : 32'd2, pattern[i], "history fill");
        end
        pc = 32'h0000_1234;
        predict(pc, "fixed pc", got);
        exp = {1'b1, model_pht[pc[IW+1:2] ^ pattern][1], pc[IW+1:2] ^ pattern};
        check_predict(got, exp, "hash with known history");
    endtask

    task automatic random_mix();
        branch_pkg::predict_rsp_t got;
        logic [2:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [IW-1:0] idx;
        for (int i = 0; i < 40; i++) begin
            // A small index set so counters actually move
            idx = $urandom_range(8'h13, 8'h10);
            if ($urandom_range(1, 0) == 0) begin
                predict(pc_for_index(idx), $sformatf("mix predict %0d", i), got);
            end else begin
                op = MIX_OPS[$urandom_range(5, 0)];
                a  = $urandom;
                b  = ($urandom_range(3, 0) == 0) ? a : $urandom;
                resolve(op, a, b, idx, $urandom_range(1, 0), int_branch_taken(op, a, b),
                        $sformatf("mix resolve %0d", i));
            end
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        void'($urandom(32'h92a4_075a));
        clk               = 1'b0;
        rstn              = 1'b0;
        predict_req       = '0;
        resolve_req_valid = 1'b0;
        resolve_req       = '0;
        errors            = 0;
        checks            = 0;
        model_hist        = '0;
        for (int i = 0; i < (1 << IW); i++) begin
            model_pht[i] = 2'd1;
        end

        reset_and_ready();
        integer_branches();
        float_branches();
        counter_training();
        history_hash();
        random_mix();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== src/branch_predict_top.sv ====
`timescale 1ns/1ps

`include "branch_config.svh"

module branch_predict_top (
    input  logic                        clk,
    input  logic                        rstn,
    input  branch_pkg::predict_req_t    predict_req,
    output branch_pkg::predict_rsp_t    predict_rsp,
    input  logic                        resolve_req_valid,
    input  branch_pkg::resolve_req_t    resolve_req,
    output logic                        resolve_ack,
    output branch_pkg::resolve_rsp_t    resolve_rsp,
    output logic                        ready
);

    branch_pkg::branch_op_e     op;
    logic [`BP_XLEN-1:0]        src0;
    logic [`BP_XLEN-1:0]        src1;
    logic                       flag;
    logic                       update;
    branch_pkg::pht_update_t    update_data;

    branch_resolve resolve0 (
        .clk         (clk),
        .rstn        (rstn),
        .req_valid   (resolve_req_valid),
        .req         (resolve_req),
        .ack         (resolve_ack),
        .rsp         (resolve_rsp),
        .op          (op),
        .src0        (src0),
        .src1        (src1),
        .flag        (flag),
        .update      (update),
        .update_data (update_data),
        .ready       (ready)
    );

    branch_unit bu0 (
        .op   (op),
        .src0 (src0),
        .src1 (src1),
        .flag (flag)
    );

    gshare_predictor pred0 (
        .clk         (clk),
        .rstn        (rstn),
        .predict_req (predict_req),
        .predict_rsp (predict_rsp),
        .update      (update),
        .update_data (update_data),
        .ready       (ready)
    );

endmodule

// ==== src/branch_resolve.sv ====
`timescale 1ns/1ps

`include "branch_config.svh"

module branch_resolve (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        req_valid,
    input  branch_pkg::resolve_req_t    req,
    output logic                        ack,
    output branch_pkg::resolve_rsp_t    rsp,
    output branch_pkg::branch_op_e      op,
    output logic [`BP_XLEN-1:0]         src0,
    output logic [`BP_XLEN-1:0]         src1,
    input  logic                        flag,
    output logic                        update,
    output branch_pkg::pht_update_t     update_data,
    input  logic                        ready
);

    typedef enum logic [2:0] {
        IDLE,
        UPDATE,
        WRITE,
        ACK,
        WAIT_LOW
    } state_e;

    state_e                     state;
    branch_pkg::resolve_req_t   req_q;
    logic                       taken_q;
    logic                       mispredict_q;

    ////////////////////
    // Handshake FSM
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
            ack   <= 1'b0;
        end else begin
            // ack trails the state by one edge, so it also falls one late
            ack <= (state == ACK) || (state == WAIT_LOW);
            case (state)
                IDLE: begin
                    if (req_valid && ready && !ack) begin
                        state <= UPDATE;
                    end
                end
                UPDATE:   state <= WRITE;
                WRITE:    state <= ACK;
                ACK:      state <= WAIT_LOW;
                WAIT_LOW: begin
                    if (!req_valid) begin
                        state <= IDLE;
                    end
                end
                default:  state <= IDLE;
            endcase
        end
    end

    // Payload captured while idle, held for the whole transaction
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            req_q <= req;
        end
        if (state == UPDATE) begin
            taken_q      <= flag;
            mispredict_q <= flag ^ req_q.pred_taken;
        end
    end

    assign op   = req_q.op;
    assign src0 = req_q.src0;
    assign src1 = req_q.src1;

    assign update            = (state == UPDATE);
    assign update_data.index = req_q.index;
    assign update_data.taken = flag;

    assign rsp.taken      = taken_q;
    assign rsp.mispredict = mispredict_q;

    a_req_held_until_ack: assert property (
        @(posedge clk) disable iff (!rstn) $fell(req_valid) |-> ack
    );

    a_update_single_cycle: assert property (
        @(posedge clk) disable iff (!rstn) update |=> !update
    );

endmodule

// ==== src/gshare_predictor.sv ====
`timescale 1ns/1ps

`include "branch_config.svh"

module gshare_predictor (
    input  logic                        clk,
    input  logic                        rstn,
    input  branch_pkg::predict_req_t    predict_req,
    output branch_pkg::predict_rsp_t    predict_rsp,
    input  logic                        update,
    input  branch_pkg::pht_update_t     update_data,
    output logic                        ready
);

    logic [`BP_PHT_INDEX_WIDTH-1:0] history;
    logic [`BP_PHT_INDEX_WIDTH-1:0] pred_index;
    logic [`BP_PHT_INDEX_WIDTH-1:0] pred_index_q;
    logic                           pred_valid_q;
    logic [1:0]                     pred_counter;

    logic                           wr_pending;
    logic [`BP_PHT_INDEX_WIDTH-1:0] upd_index_q;
    logic                           upd_taken_q;
    logic [`BP_PHT_INDEX_WIDTH-1:0] upd_addr;
    logic [1:0]                     upd_old;
    logic [1:0]                     upd_new;

    ////////////////////
    // Prediction path
    ////////////////////

    // Word-aligned PC bits hashed with history at the request edge
    assign pred_index = predict_req.pc[`BP_PHT_INDEX_WIDTH+1:2] ^ history;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pred_valid_q <= 1'b0;
        end else begin
            pred_valid_q <= predict_req.valid && ready;
        end
    end

    always_ff @(posedge clk) begin
        pred_index_q <= pred_index;
    end

    assign predict_rsp.valid = pred_valid_q;
    assign predict_rsp.taken = pred_counter[1];
    assign predict_rsp.index = pred_index_q;

    ////////////////////
    // Update path
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            history    <= '0;
            wr_pending <= 1'b0;
        end else begin
            wr_pending <= update && ready;
            if (update && ready) begin
                history <= {history[`BP_PHT_INDEX_WIDTH-2:0], update_data.taken};
            end
        end
    end

    always_ff @(posedge clk) begin
        upd_index_q <= update_data.index;
        upd_taken_q <= update_data.taken;
    end

    // Read on the update cycle, write back on the next
    assign upd_addr = wr_pending ? upd_index_q : update_data.index;

    // Saturating 2-bit counter step
    always_comb begin
        if (upd_taken_q) begin
            upd_new = (upd_old == 2'd3) ? upd_old : upd_old + 2'd1;
        end else begin
            upd_new = (upd_old == 2'd0) ? upd_old : upd_old - 2'd1;
        end
    end

    pht_ram pht0 (
        .clk         (clk),
        .rstn        (rstn),
        .rd_addr     (pred_index),
        .rd_data     (pred_counter),
        .upd_addr    (upd_addr),
        .upd_rd_data (upd_old),
        .upd_we      (wr_pending),
        .upd_wr_data (upd_new),
        .ready       (ready)
    );

endmodule

// ==== src/pht_ram.sv ====
`timescale 1ns/1ps

`include "branch_config.svh"

module pht_ram (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic [`BP_PHT_INDEX_WIDTH-1:0]  rd_addr,
    output logic [1:0]                      rd_data,
    input  logic [`BP_PHT_INDEX_WIDTH-1:0]  upd_addr,
    output logic [1:0]                      upd_rd_data,
    input  logic                            upd_we,
    input  logic [1:0]                      upd_wr_data,
    output logic                            ready
);

    localparam int DEPTH = 1 << `BP_PHT_INDEX_WIDTH;

    logic [1:0] mem [DEPTH];

    logic [`BP_PHT_INDEX_WIDTH-1:0] clr_addr;
    logic [`BP_PHT_INDEX_WIDTH-1:0] wr_addr;
    logic [1:0]                     wr_data;
    logic                           wr_en;

    ////////////////////
    // Clear walk
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            clr_addr <= '0;
            ready    <= 1'b0;
        end else if (!ready) begin
            clr_addr <= clr_addr + 1'b1;
            if (clr_addr == '1) begin
                ready <= 1'b1;
            end
        end
    end

    // Walk owns the write port until ready, counters start weakly not taken
    assign wr_addr = ready ? upd_addr : clr_addr;
    assign wr_data = ready ? upd_wr_data : 2'd1;
    assign wr_en   = ready ? upd_we : 1'b1;

    ////////////////////
    // Array
    ////////////////////

    // Read-first on both ports
    always_ff @(posedge clk) begin
        rd_data     <= mem[rd_addr];
        upd_rd_data <= mem[upd_addr];
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    a_no_write_before_ready: assert property (
        @(posedge clk) disable iff (!rstn) upd_we |-> ready
    );

endmodule

// ==== src/branch_unit.sv ====
`timescale 1ns/1ps

`include "branch_config.svh"

module branch_unit (
    input  branch_pkg::branch_op_e  op,
    input  logic [`BP_XLEN-1:0]     src0,
    input  logic [`BP_XLEN-1:0]     src1,
    output logic                    flag
);

    logic fp_eq;
    logic fp_le;
    logic int_eq;
    logic int_lt;

    fp_compare fp_cmp0 (
        .a  (src0),
        .b  (src1),
        .eq (fp_eq),
        .le (fp_le)
    );

    // Shared integer comparisons
    assign int_eq = (src0 == src1);
    assign int_lt = ($signed(src0) < $signed(src1));

    always_comb begin
        case (op)
            branch_pkg::BR_BEQ: begin
                flag = int_eq;
            end
            branch_pkg::BR_BNE: begin
                flag = !int_eq;
            end
            branch_pkg::BR_BLT: begin
                flag = int_lt;
            end
            branch_pkg::BR_BGE: begin
                flag = !int_lt;
            end
            branch_pkg::BR_FBEQ: begin
                flag = fp_eq;
            end
            branch_pkg::BR_FBLE: begin
                flag = fp_le;
            end
            default: begin
                // Unused codes fall through as not taken
                flag = 1'b0;
            end
        endcase
    end

endmodule

// ==== src/fp_compare.sv ====
`timescale 1ns/1ps

`include "branch_config.svh"

module fp_compare (
    input  logic [`BP_XLEN-1:0] a,
    input  logic [`BP_XLEN-1:0] b,
    output logic                eq,
    output logic                le
);

    logic       a_nan;
    logic       b_nan;
    logic       any_nan;
    logic       both_zero;
    logic       a_sign;
    logic       b_sign;
    logic [30:0] a_mag;
    logic [30:0] b_mag;
    logic       lt;

    assign a_sign = a[31];
    assign b_sign = b[31];
    assign a_mag  = a[30:0];
    assign b_mag  = b[30:0];

    // Exponent all ones with a nonzero mantissa
    assign a_nan   = (a[30:23] == 8'hff) && (a[22:0] != 23'd0);
    assign b_nan   = (b[30:23] == 8'hff) && (b[22:0] != 23'd0);
    assign any_nan = a_nan || b_nan;

    // +0 and -0 are the same value
    assign both_zero = (a_mag == 31'd0) && (b_mag == 31'd0);

    // Sign-magnitude ordering, negatives run backwards
    always_comb begin
        if (both_zero) begin
            lt = 1'b0;
        end else if (a_sign != b_sign) begin
            lt = a_sign;
        end else if (a_sign) begin
            lt = a_mag > b_mag;
        end else begin
            lt = a_mag < b_mag;
        end
    end

    assign eq = !any_nan && ((a == b) || both_zero);
    assign le = !any_nan && ((a == b) || both_zero || lt);

endmodule

// ==== src/branch_pkg.sv ====
package branch_pkg;

`include "branch_config.svh"

    ////////////////////
    // Opcodes
    ////////////////////

    // Codes 6 and 7 are unused and never taken
    typedef enum logic [2:0] {
        BR_BEQ  = 3'd0,
        BR_BNE  = 3'd1,
        BR_BLT  = 3'd2,
        BR_BGE  = 3'd3,
        BR_FBEQ = 3'd4,
        BR_FBLE = 3'd5
    } branch_op_e;

    ////////////////////
    // Port payloads
    ////////////////////

    typedef struct packed {
        logic                  valid;
        logic [`BP_XLEN-1:0]   pc;
    } predict_req_t;

    // Index travels with the branch so the update trains the same entry
    typedef struct packed {
        logic                            valid;
        logic                            taken;
        logic [`BP_PHT_INDEX_WIDTH-1:0]  index;
    } predict_rsp_t;

    typedef struct packed {
        branch_op_e                      op;
        logic [`BP_XLEN-1:0]             src0;
        logic [`BP_XLEN-1:0]             src1;
        logic [`BP_PHT_INDEX_WIDTH-1:0]  index;
        logic                            pred_taken;
    } resolve_req_t;

    typedef struct packed {
        logic taken;
        logic mispredict;
    } resolve_rsp_t;

    // Resolver to predictor training
    typedef struct packed {
        logic [`BP_PHT_INDEX_WIDTH-1:0]  index;
        logic                            taken;
    } pht_update_t;

endpackage

// ==== src/branch_config.svh ====
`ifndef BRANCH_CONFIG_SVH
`define BRANCH_CONFIG_SVH

// Operand and PC width
`define BP_XLEN 32

// Pattern table index width
// Also the length of the global history register
`define BP_PHT_INDEX_WIDTH 8

`endif
